//--- Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_isa_pkg.sv
  - logic/rv_core_pkg.sv
  - logic/core_control.sv
  - logic/inst_decoder.sv
  - logic/alu.sv
  - logic/load_store_unit.sv
  - logic/register_file.sv
  - logic/rv_core.sv
  - target: test
    files:
      - testbench/rv_core_tb.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  rv_isa_pkg::op_class_e        op_class,
	input  rv_isa_pkg::alu_op_e          alu_op,
	input  logic [rv_core_pkg::xlen-1:0] rs1_val,
	input  logic [rv_core_pkg::xlen-1:0] rs2_val,
	input  logic [rv_core_pkg::xlen-1:0] imm,
	input  logic [rv_core_pkg::xlen-1:0] pc,
	output logic [rv_core_pkg::xlen-1:0] alu_result,
	output logic [rv_core_pkg::xlen-1:0] next_pc
);

	logic [rv_core_pkg::xlen-1:0] a, b;
	logic [rv_core_pkg::xlen-1:0] sum;
	logic [4:0] shamt;
	logic lt_s, lt_u;
	logic taken;

	// upper takes the pc, lui then passes b through
	assign a = (op_class == rv_isa_pkg::UPPER) ? pc : rs1_val;
	assign b = (op_class == rv_isa_pkg::ALU_REG || op_class == rv_isa_pkg::BRANCH) ?
		rs2_val : imm;

	assign sum   = a + b;
	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		taken = 1'b0;
		case (alu_op)
			rv_isa_pkg::ADD:    alu_result = sum;
			rv_isa_pkg::SUB:    alu_result = a - b;
			rv_isa_pkg::SLL:    alu_result = a << shamt;
			rv_isa_pkg::SLT:    alu_result = {31'b0, lt_s};
			rv_isa_pkg::SLTU:   alu_result = {31'b0, lt_u};
			rv_isa_pkg::XOR:    alu_result = a ^ b;
			rv_isa_pkg::SRL:    alu_result = a >> shamt;
			rv_isa_pkg::SRA:    alu_result = $signed(a) >>> shamt;
			rv_isa_pkg::OR:     alu_result = a | b;
			rv_isa_pkg::AND:    alu_result = a & b;
			rv_isa_pkg::PASS_B: alu_result = b;
			default: begin
				case (alu_op)
					rv_isa_pkg::EQ:  taken = (a == b);
					rv_isa_pkg::NE:  taken = (a != b);
					rv_isa_pkg::LT:  taken = lt_s;
					rv_isa_pkg::GE:  taken = !lt_s;
					rv_isa_pkg::LTU: taken = lt_u;
					default:         taken = !lt_u;
				endcase
				alu_result = {31'b0, taken};
			end
		endcase
	end

	always_comb begin
		case (op_class)
			rv_isa_pkg::JUMP:     next_pc = pc + imm;
			rv_isa_pkg::JUMP_REG: next_pc = {sum[31:1], 1'b0};
			rv_isa_pkg::BRANCH:   next_pc = taken ? pc + imm : pc + 32'd4;
			default:              next_pc = pc + 32'd4;
		endcase
	end

endmodule

//--- logic/core_control.sv
`timescale 1ns/1ps

module core_control (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_isa_pkg::op_class_e op_class,
	input  logic                  mem_ready,
	output logic                  ir_load,
	output logic                  mem_rd,
	output logic                  mem_wr,
	output logic                  addr_sel_data,
	output logic                  reg_wen,
	output logic                  pc_wen,
	output logic                  retire,
	output logic                  halted,
	output logic                  illegal
);

	rv_core_pkg::ctrl_state_e state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= rv_core_pkg::FETCH;
			mem_rd  <= 1'b0;
			mem_wr  <= 1'b0;
			halted  <= 1'b0;
			illegal <= 1'b0;
		end else begin
			case (state)
				rv_core_pkg::FETCH: begin
					if (mem_ready) begin
						mem_rd <= 1'b0;
						state  <= rv_core_pkg::EXECUTE;
					end else begin
						mem_rd <= 1'b1; // raised one cycle after entry
					end
				end
				rv_core_pkg::EXECUTE: begin
					case (op_class)
						rv_isa_pkg::LOAD: begin
							mem_rd <= 1'b1;
							state  <= rv_core_pkg::MEMORY;
						end
						rv_isa_pkg::STORE: begin
							mem_wr <= 1'b1;
							state  <= rv_core_pkg::MEMORY;
						end
						rv_isa_pkg::HALT: begin
							halted <= 1'b1;
							state  <= rv_core_pkg::HALTED;
						end
						rv_isa_pkg::ILLEGAL: begin
							halted  <= 1'b1;
							illegal <= 1'b1;
							state   <= rv_core_pkg::HALTED;
						end
						default: state <= rv_core_pkg::WRITEBACK;
					endcase
				end
				rv_core_pkg::MEMORY: begin
					if (mem_ready) begin
						mem_rd <= 1'b0;
						mem_wr <= 1'b0;
						state  <= rv_core_pkg::WRITEBACK;
					end
				end
				rv_core_pkg::WRITEBACK: state <= rv_core_pkg::FETCH;
				default: state <= rv_core_pkg::HALTED; // stays until reset
			endcase
		end
	end

	assign ir_load       = (state == rv_core_pkg::FETCH) && mem_ready;
	assign addr_sel_data = (state == rv_core_pkg::MEMORY);
	assign pc_wen        = (state == rv_core_pkg::WRITEBACK);
	assign retire        = (state == rv_core_pkg::WRITEBACK);
	assign reg_wen       = (state == rv_core_pkg::WRITEBACK) &&
		(op_class != rv_isa_pkg::BRANCH) && (op_class != rv_isa_pkg::STORE);

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  logic [rv_core_pkg::xlen-1:0]       inst,
	output rv_isa_pkg::op_class_e             op_class,
	output rv_isa_pkg::alu_op_e               alu_op,
	output rv_isa_pkg::mem_size_e             mem_size,
	output logic                              load_unsigned,
	output logic [rv_core_pkg::reg_addr_w-1:0] rd,
	output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
	output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
	output logic [rv_core_pkg::xlen-1:0]       imm
);

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rv_core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic funct7_ok;

	function automatic rv_isa_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  arith_op = alt ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
			3'b001:  arith_op = rv_isa_pkg::SLL;
			3'b010:  arith_op = rv_isa_pkg::SLT;
			3'b011:  arith_op = rv_isa_pkg::SLTU;
			3'b100:  arith_op = rv_isa_pkg::XOR;
			3'b101:  arith_op = alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
			3'b110:  arith_op = rv_isa_pkg::OR;
			default: arith_op = rv_isa_pkg::AND;
		endcase
	endfunction

	assign funct3 = inst[rv_isa_pkg::funct3_lsb +: 3];
	assign funct7 = inst[rv_isa_pkg::funct7_lsb +: 7];
	assign rd     = inst[rv_isa_pkg::rd_lsb +: rv_core_pkg::reg_addr_w];
	assign rs1    = inst[rv_isa_pkg::rs1_lsb +: rv_core_pkg::reg_addr_w];
	assign rs2    = inst[rv_isa_pkg::rs2_lsb +: rv_core_pkg::reg_addr_w];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// only sub and sra may set the alternate funct7
	assign funct7_ok = (funct7 == 7'b0) ||
		((funct7 == rv_isa_pkg::funct7_alt) && (funct3 == 3'b000 || funct3 == 3'b101));

	assign mem_size      = rv_isa_pkg::mem_size_e'(funct3[1:0]);
	assign load_unsigned = funct3[2];

	always_comb begin
		op_class = rv_isa_pkg::ILLEGAL;
		alu_op   = rv_isa_pkg::ADD;
		imm      = imm_i;
		case (inst[6:0])
			rv_isa_pkg::OPC_OP: begin
				alu_op = arith_op(funct3, funct7[5]);
				if (funct7_ok) op_class = rv_isa_pkg::ALU_REG;
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
				if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7_ok)
					op_class = rv_isa_pkg::ALU_IMM;
			end
			rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
				op_class = rv_isa_pkg::UPPER;
				alu_op   = inst[5] ? rv_isa_pkg::PASS_B : rv_isa_pkg::ADD;
				imm      = imm_u;
			end
			rv_isa_pkg::OPC_JAL: begin
				op_class = rv_isa_pkg::JUMP;
				imm      = imm_j;
			end
			rv_isa_pkg::OPC_JALR: if (funct3 == 3'b000) op_class = rv_isa_pkg::JUMP_REG;
			rv_isa_pkg::OPC_BRANCH: begin
				imm = imm_b;
				case (funct3)
					3'b000:  alu_op = rv_isa_pkg::EQ;
					3'b001:  alu_op = rv_isa_pkg::NE;
					3'b100:  alu_op = rv_isa_pkg::LT;
					3'b101:  alu_op = rv_isa_pkg::GE;
					3'b110:  alu_op = rv_isa_pkg::LTU;
					default: alu_op = rv_isa_pkg::GEU;
				endcase
				if (funct3[2:1] != 2'b01) op_class = rv_isa_pkg::BRANCH;
			end
			rv_isa_pkg::OPC_LOAD: begin
				if (funct3[1:0] != 2'b11 && funct3 != 3'b110) op_class = rv_isa_pkg::LOAD;
			end
			rv_isa_pkg::OPC_STORE: begin
				imm = imm_s;
				if (!funct3[2] && funct3[1:0] != 2'b11) op_class = rv_isa_pkg::STORE;
			end
			rv_isa_pkg::OPC_SYSTEM: if (inst == rv_isa_pkg::ebreak_word) op_class = rv_isa_pkg::HALT;
			default: op_class = rv_isa_pkg::ILLEGAL; // fence lands here
		endcase
	end

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
	input  logic [1:0]                   addr_low,
	input  rv_isa_pkg::mem_size_e        mem_size,
	input  logic                         load_unsigned,
	input  logic [rv_core_pkg::xlen-1:0] store_val,
	input  logic [rv_core_pkg::xlen-1:0] mem_rdata,
	output logic [rv_core_pkg::xlen-1:0] mem_wdata,
	output logic [3:0]                   mem_wmask,
	output logic [rv_core_pkg::xlen-1:0] load_data
);

	logic [rv_core_pkg::xlen-1:0] lane;

	// store side, replicate then mask the lane
	always_comb begin
		case (mem_size)
			rv_isa_pkg::BYTE: begin
				mem_wdata = {4{store_val[7:0]}};
				mem_wmask = 4'b0001 << addr_low;
			end
			rv_isa_pkg::HALF: begin
				mem_wdata = {2{store_val[15:0]}};
				mem_wmask = 4'b0011 << {addr_low[1], 1'b0};
			end
			default: begin
				mem_wdata = store_val;
				mem_wmask = 4'b1111;
			end
		endcase
	end

	assign lane = mem_rdata >> {addr_low, 3'b000}; // selected lane to bit 0

	always_comb begin
		case (mem_size)
			rv_isa_pkg::BYTE:
				load_data = {{24{!load_unsigned && lane[7]}}, lane[7:0]};
			rv_isa_pkg::HALF:
				load_data = {{16{!load_unsigned && lane[15]}}, lane[15:0]};
			default:
				load_data = mem_rdata;
		endcase
	end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                               clk,
	input  logic [rv_core_pkg::reg_addr_w-1:0] raddr1,
	input  logic [rv_core_pkg::reg_addr_w-1:0] raddr2,
	output logic [rv_core_pkg::xlen-1:0]       rdata1,
	output logic [rv_core_pkg::xlen-1:0]       rdata2,
	input  logic                               wen,
	input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
	input  logic [rv_core_pkg::xlen-1:0]       wdata,
	output logic [rv_core_pkg::xlen-1:0]       x10
);

	logic [rv_core_pkg::xlen-1:0] regs [2**rv_core_pkg::reg_addr_w];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// x0 reads as zero whatever the array holds
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
	assign x10    = regs[10];

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic                         clk,
	input  logic                         rst,
	output logic [rv_core_pkg::xlen-1:0] mem_addr,
	output logic                         mem_rd,
	output logic                         mem_wr,
	output logic [rv_core_pkg::xlen-1:0] mem_wdata,
	output logic [3:0]                   mem_wmask,
	input  logic [rv_core_pkg::xlen-1:0] mem_rdata,
	input  logic                         mem_ready,
	output logic                         retire,
	output logic [rv_core_pkg::xlen-1:0] retire_pc,
	output logic                         halted,
	output logic [rv_core_pkg::xlen-1:0] halt_ret,
	output logic                         illegal
);

	logic [rv_core_pkg::xlen-1:0] pc, ir, load_word;
	logic [rv_core_pkg::xlen-1:0] imm, rs1_val, rs2_val, alu_result, next_pc;
	logic [rv_core_pkg::xlen-1:0] load_data, wb_data, x10;
	logic [rv_core_pkg::reg_addr_w-1:0] rd, rs1, rs2;
	rv_isa_pkg::op_class_e op_class;
	rv_isa_pkg::alu_op_e alu_op;
	rv_isa_pkg::mem_size_e mem_size;
	logic load_unsigned, ir_load, addr_sel_data, reg_wen, pc_wen;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= rv_core_pkg::reset_pc;
		else if (pc_wen)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		if (ir_load) ir <= mem_rdata;
		if (addr_sel_data && mem_ready) load_word <= mem_rdata; // read data lasts one cycle
	end

	core_control u_control (.clk, .rst, .op_class, .mem_ready, .ir_load, .mem_rd, .mem_wr,
		.addr_sel_data, .reg_wen, .pc_wen, .retire, .halted, .illegal);

	inst_decoder u_decoder (.inst(ir), .op_class, .alu_op, .mem_size, .load_unsigned,
		.rd, .rs1, .rs2, .imm);

	alu u_alu (.op_class, .alu_op, .rs1_val, .rs2_val, .imm, .pc, .alu_result, .next_pc);

	load_store_unit u_lsu (.addr_low(alu_result[1:0]), .mem_size, .load_unsigned,
		.store_val(rs2_val), .mem_rdata(load_word), .mem_wdata, .mem_wmask, .load_data);

	register_file u_regs (.clk, .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_val),
		.rdata2(rs2_val), .wen(reg_wen), .waddr(rd), .wdata(wb_data), .x10);

	always_comb begin
		case (op_class)
			rv_isa_pkg::LOAD:                     wb_data = load_data;
			rv_isa_pkg::JUMP, rv_isa_pkg::JUMP_REG: wb_data = pc + 32'd4; // link
			default:                              wb_data = alu_result;
		endcase
	end

	assign mem_addr  = addr_sel_data ? alu_result : pc;
	assign retire_pc = pc; // pc moves on at the end of writeback
	assign halt_ret  = x10;

endmodule

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	// controller sequence, one instruction at a time
	typedef enum logic [2:0] {
		FETCH,
		EXECUTE,
		MEMORY, // loads and stores only
		WRITEBACK,
		HALTED
	} ctrl_state_e;

endpackage

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes, bits 6:0
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [4:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B,
		EQ, NE, LT, GE, LTU, GEU // branch compares
	} alu_op_e;

	typedef enum logic [3:0] {
		ALU_REG, ALU_IMM, UPPER, JUMP, JUMP_REG, BRANCH, LOAD, STORE, HALT, ILLEGAL
	} op_class_e;

	// same as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} mem_size_e;

	localparam logic [31:0] ebreak_word = 32'h0010_0073;

	// instruction field positions
	localparam int rd_lsb = 7;
	localparam int funct3_lsb = 12;
	localparam int rs1_lsb = 15;
	localparam int rs2_lsb = 20;
	localparam int funct7_lsb = 25;
	localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra

endpackage

//--- rv_core.f
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/core_control.sv
logic/inst_decoder.sv
logic/alu.sv
logic/load_store_unit.sv
logic/register_file.sv
logic/rv_core.sv
testbench/rv_core_tb.sv

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

	localparam int prog_len = 231; // 31 init slots and 200 random slots before the ebreak
	localparam int idle_limit = 200;

	logic clk, rst, mem_rd, mem_wr, mem_ready, retire, halted, illegal;
	logic [31:0] mem_addr, mem_wdata, mem_rdata, retire_pc, halt_ret;
	logic [3:0] mem_wmask;

	integer seed;
	logic first_ready_seen;
	logic [31:0] mem [1024]; // aliased on addr[11:2]
	logic [31:0] ref_mem [1024];
	logic [31:0] regs [32];
	logic [31:0] exp_x10;
	logic [31:0] pc_q [$];
	logic [31:0] st_addr_q [$];
	logic [31:0] st_data_q [$];
	logic [3:0] st_mask_q [$];
	logic [31:0] req_addr, req_wdata;
	logic [3:0] req_wmask;
	logic req_rd, req_wr;

	rv_core DUT (.clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_wr(mem_wr),
		.mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .mem_rdata(mem_rdata),
		.mem_ready(mem_ready), .retire(retire), .retire_pc(retire_pc), .halted(halted),
		.halt_ret(halt_ret), .illegal(illegal));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("ERROR at t=%0t: %s", $time, why);
		$display("Test failures found");
		$fatal(1);
	endtask

	function automatic int rnd_below(input int n);
		rnd_below = {$random(seed)} % n;
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		sext12 = {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] lane_bits(input logic [3:0] m);
		lane_bits = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	// rv32i arithmetic by funct3 and the funct7 alt bit
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: alu_ref = alt ? a - b : a + b;
			3'd1: alu_ref = a << b[4:0];
			3'd2: alu_ref = {31'b0, $signed(a) < $signed(b)};
			3'd3: alu_ref = {31'b0, a < b};
			3'd4: alu_ref = a ^ b;
			3'd5: begin
				if (alt)
					alu_ref = $signed(a) >>> b[4:0];
				else
					alu_ref = a >> b[4:0];
			end
			3'd6: alu_ref = a | b;
			default: alu_ref = a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: branch_taken = a == b;
			3'd1: branch_taken = a != b;
			3'd4: branch_taken = $signed(a) < $signed(b);
			3'd5: branch_taken = $signed(a) >= $signed(b);
			3'd6: branch_taken = a < b;
			default: branch_taken = a >= b;
		endcase
	endfunction

	task automatic put_word(input int slot, input logic [31:0] word);
		mem[slot] = word;
		ref_mem[slot] = word;
	endtask

	task automatic fill_memory();
		logic [31:0] a;
		for (int k = 0; k < 1024; k++) begin
			a = rv_core_pkg::reset_pc + 32'(4 * k);
			put_word(k, (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]});
		end
	endtask

	// the ISA model runs the program as it is generated
	task automatic build_program();
		int kind, w, next, cur;
		logic [4:0] rd, rs1, rs2, rs;
		logic [2:0] f3;
		logic [11:0] imm12;
		logic [31:0] pc, res, imm, addr, word, lane;
		logic [3:0] mask;
		logic alt, wr;
		for (int k = 0; k < 32; k++) regs[k] = '0;
		for (int k = 0; k < 31; k++) begin
			imm12 = 12'(rnd_below(4096));
			put_word(k, {imm12, 5'd0, 3'd0, 5'(k + 1), 7'h13});
			regs[k + 1] = sext12(imm12);
			pc_q.push_back(rv_core_pkg::reset_pc + 32'(4 * k));
		end
		cur = 31;
		for (int i = 31; i < prog_len; i++) begin
			if (i != cur) begin
				// filler for slots never reached
				put_word(i, {12'(rnd_below(4096)), 8'd0, 5'(rnd_below(32)), 7'h13});
			end else begin
				kind = rnd_below(10);
				if (kind == 7 && i + 1 >= prog_len) kind = 2;
				rd = (rnd_below(4) == 0) ? 5'd10 : 5'(rnd_below(32)); // feed x10 often
				rs1 = 5'(rnd_below(32));
				rs2 = 5'(rnd_below(32));
				f3 = 3'(rnd_below(8));
				imm12 = 12'(rnd_below(4096));
				alt = rnd_below(2) == 1;
				w = 1 + rnd_below(8);
				if (i + w > prog_len) w = prog_len - i;
				pc = rv_core_pkg::reset_pc + 32'(4 * i);
				wr = 1'b1;
				next = i + 1;
				addr = 32'(1024 + 4 * rnd_below(256)); // data window at words 256 to 511
				case (kind)
					0, 1: begin
						alt = alt && (f3 == 3'd0 || f3 == 3'd5);
						word = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
						res = alu_ref(f3, alt, regs[rs1], regs[rs2]);
					end
					2, 3: begin
						alt = alt && f3 == 3'd5;
						if (f3 == 3'd1 || f3 == 3'd5) imm12 = {alt ? 7'h20 : 7'h00, imm12[4:0]};
						word = {imm12, rs1, f3, rd, 7'h13};
						res = alu_ref(f3, alt, regs[rs1], sext12(imm12));
					end
					4: begin
						imm = 32'(rnd_below(1 << 20)) << 12;
						word = {imm[31:12], rd, alt ? 7'h37 : 7'h17}; // lui or auipc
						res = alt ? imm : pc + imm;
					end
					5: begin
						imm = 32'(4 * w);
						word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
						res = pc + 4;
						next = i + w;
					end
					6: begin
						f3 = 3'(rnd_below(6));
						if (f3 > 3'd1) f3 = f3 + 3'd2;
						imm = 32'(4 * w);
						word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
						wr = 1'b0;
						if (branch_taken(f3, regs[rs1], regs[rs2])) next = i + w;
					end
					7: begin
						// auipc then jalr so the base is a known pc
						rs = 5'(1 + rnd_below(31));
						put_word(i, {20'h0, rs, 7'h17});
						regs[rs] = pc;
						pc_q.push_back(pc);
						i++;
						pc = pc + 4;
						if (i + w > prog_len) w = prog_len - i;
						imm = 32'(4 + 4 * w);
						word = {imm[11:0], rs, 3'b000, rd, 7'h67};
						res = pc + 4;
						next = i + w;
					end
					8: begin
						f3 = 3'(rnd_below(5));
						if (f3 > 3'd2) f3 = f3 + 3'd1;
						if (f3[1:0] == 2'd0) addr = addr + 32'(rnd_below(4));
						if (f3[1:0] == 2'd1) addr = addr + 32'(2 * rnd_below(2));
						word = {addr[11:0], 5'd0, f3, rd, 7'h03};
						lane = ref_mem[addr[11:2]] >> {addr[1:0], 3'b000};
						case (f3)
							3'd0: res = {{24{lane[7]}}, lane[7:0]};
							3'd1: res = {{16{lane[15]}}, lane[15:0]};
							3'd4: res = {24'b0, lane[7:0]};
							3'd5: res = {16'b0, lane[15:0]};
							default: res = lane;
						endcase
					end
					default: begin
						f3 = 3'(rnd_below(3));
						if (f3 == 3'd0) addr = addr + 32'(rnd_below(4));
						if (f3 == 3'd1) addr = addr + 32'(2 * rnd_below(2));
						word = {addr[11:5], rs2, 5'd0, f3, addr[4:0], 7'h23};
						wr = 1'b0;
						mask = (f3 == 3'd0 ? 4'b0001 : f3 == 3'd1 ? 4'b0011 : 4'b1111) << addr[1:0];
						res = regs[rs2] << {addr[1:0], 3'b000};
						ref_mem[addr[11:2]] = (ref_mem[addr[11:2]] & ~lane_bits(mask)) |
							(res & lane_bits(mask));
						st_addr_q.push_back(addr);
						st_mask_q.push_back(mask);
						st_data_q.push_back(res);
					end
				endcase
				put_word(i, word);
				pc_q.push_back(pc);
				if (wr && rd != 5'd0) regs[rd] = res;
				cur = next;
			end
		end
		put_word(prog_len, rv_isa_pkg::ebreak_word);
		exp_x10 = regs[10];
	endtask

	task automatic check_request_held();
		check("mem_addr", mem_addr, req_addr);
		check("mem_rd", mem_rd, req_rd);
		check("mem_wr", mem_wr, req_wr);
		if (req_wr) begin
			check("mem_wdata", mem_wdata, req_wdata);
			check("mem_wmask", mem_wmask, req_wmask);
		end
	endtask

	// memory with 1 to 4 cycles of latency
	initial begin : memory_model
		int lat;
		logic [3:0] exp_mask;
		logic [31:0] exp_data;
		forever begin
			@(posedge clk);
			if (!rst && (mem_rd || mem_wr)) begin
				req_addr = mem_addr;
				req_rd = mem_rd;
				req_wr = mem_wr;
				req_wdata = mem_wdata;
				req_wmask = mem_wmask;
				lat = 1 + rnd_below(4);
				for (int k = 1; k < lat; k++) begin
					@(posedge clk);
					check_request_held();
				end
				#1;
				if (req_wr) begin
					if (st_addr_q.size() == 0) abort_run("store seen that the model never made");
					exp_mask = st_mask_q.pop_front();
					exp_data = st_data_q.pop_front();
					check("store address", req_addr, st_addr_q.pop_front());
					check("mem_wmask", req_wmask, exp_mask);
					check("mem_wdata lanes", req_wdata & lane_bits(exp_mask),
						exp_data & lane_bits(exp_mask));
					for (int b = 0; b < 4; b++)
						if (req_wmask[b]) mem[req_addr[11:2]][8*b +: 8] = req_wdata[8*b +: 8];
				end else begin
					mem_rdata = mem[req_addr[11:2]];
				end
				mem_ready = 1'b1;
				@(posedge clk);
				check_request_held(); // still held in the ready cycle
				#1 mem_ready = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			first_ready_seen = 1'b0;
		end else begin
			if (mem_rd && mem_wr) abort_run("mem_rd and mem_wr were high in the same cycle");
			if (!first_ready_seen) begin
				check("retire before first ready", retire, 1'b0);
				check("mem_wr before first ready", mem_wr, 1'b0);
				check("halted before first ready", halted, 1'b0);
				check("mem_addr before first ready", mem_addr, rv_core_pkg::reset_pc);
			end
			if (mem_ready) first_ready_seen = 1'b1;
		end
	end

	task automatic run_until_halt();
		int idle;
		logic r, h;
		logic [31:0] rpc;
		idle = 0;
		h = 1'b0;
		while (!h) begin
			@(posedge clk);
			r = retire;
			h = halted;
			rpc = retire_pc;
			idle++;
			if (r) begin
				if (pc_q.size() == 0) abort_run("retire with no instruction left in the model");
				check("retire_pc", rpc, pc_q.pop_front());
				idle = 0;
			end
			if (idle > idle_limit) abort_run("timed out waiting for retire or halted");
		end
		check("instructions left unretired", pc_q.size(), 0);
	endtask

	initial begin
		seed = 32'h4454;
		rst = 1'b1;
		mem_ready = 1'b0;
		mem_rdata = '0;
		fill_memory();
		build_program();
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		run_until_halt();
		check("illegal", illegal, 1'b0);
		check("halt_ret", halt_ret, exp_x10);
		check("stores left unseen", st_addr_q.size(), 0);

		// fence at the third slot halts as illegal
		put_word(0, {12'd5, 5'd0, 3'd0, 5'd10, 7'h13});
		put_word(1, {12'd7, 5'd0, 3'd0, 5'd11, 7'h13});
		put_word(2, 32'h0ff0_000f);
		pc_q.push_back(rv_core_pkg::reset_pc);
		pc_q.push_back(rv_core_pkg::reset_pc + 32'd4);
		#1 rst = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		run_until_halt();
		check("illegal", illegal, 1'b1);
		for (int k = 0; k < 20; k++) begin
			@(posedge clk);
			check("retire after halt", retire, 1'b0);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule
